/* mempool_sys_pkg.sv */
package mempool_sys_pkg;

  localparam int unsigned AddrWidth = 32;
  localparam int unsigned DataWidth = 32;
  localparam int unsigned StrbWidth = DataWidth / 8;

  // Routing targets, External doubles as the default port
  typedef enum logic [1:0] {
    CtrlRegisters,
    L2Memory,
    Bootrom,
    External
  } slave_target_e;

  localparam logic [AddrWidth-1:0] CtrlRegistersBaseAddr = 32'h4000_0000;
  localparam logic [AddrWidth-1:0] CtrlRegistersEndAddr  = 32'h4000_FFFF;
  localparam logic [AddrWidth-1:0] L2MemoryBaseAddr      = 32'h8000_0000;
  localparam logic [AddrWidth-1:0] L2MemoryEndAddr       = 32'h801F_FFFF;
  localparam logic [AddrWidth-1:0] BootromBaseAddr       = 32'hA000_0000;
  localparam logic [AddrWidth-1:0] BootromEndAddr        = 32'hA000_FFFF;

  // Byte offsets inside the control register window
  typedef enum logic [15:0] {
    WakeUpReg    = 16'h0000,
    EocReg       = 16'h0004,
    TcdmStartReg = 16'h0008,
    TcdmEndReg   = 16'h000C,
    NumCoresReg  = 16'h0010
  } ctrl_reg_e;

  localparam int unsigned TCDMSizePerBank = 1024; // bytes

  // Upper half of every boot ROM word
  localparam logic [15:0] BootromTag = 16'hB007;

endpackage : mempool_sys_pkg

/* addr_decode_stage.sv */
`timescale 1ns/1ps

module addr_decode_stage (
  input  logic                                    clk_i,
  input  logic                                    arst_n_i,
  input  logic                                    req_i,
  input  logic                                    we_i,
  input  logic [mempool_sys_pkg::AddrWidth-1:0]   addr_i,
  input  logic [mempool_sys_pkg::DataWidth-1:0]   wdata_i,
  input  logic [mempool_sys_pkg::StrbWidth-1:0]   strb_i,
  output logic                                    dec_valid_o,
  output mempool_sys_pkg::slave_target_e          dec_target_o,
  output logic                                    dec_we_o,
  output logic [mempool_sys_pkg::AddrWidth-1:0]   dec_addr_o,
  output logic [mempool_sys_pkg::DataWidth-1:0]   dec_wdata_o,
  output logic [mempool_sys_pkg::StrbWidth-1:0]   dec_strb_o
);

  mempool_sys_pkg::slave_target_e target_d;

  // Address map, anything outside the three windows goes out
  always_comb begin
    if (addr_i >= mempool_sys_pkg::CtrlRegistersBaseAddr &&
        addr_i <= mempool_sys_pkg::CtrlRegistersEndAddr) begin
      target_d = mempool_sys_pkg::CtrlRegisters;
    end else if (addr_i >= mempool_sys_pkg::L2MemoryBaseAddr &&
                 addr_i <= mempool_sys_pkg::L2MemoryEndAddr) begin
      target_d = mempool_sys_pkg::L2Memory;
    end else if (addr_i >= mempool_sys_pkg::BootromBaseAddr &&
                 addr_i <= mempool_sys_pkg::BootromEndAddr) begin
      target_d = mempool_sys_pkg::Bootrom;
    end else begin
      target_d = mempool_sys_pkg::External;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      dec_valid_o <= 1'b0;
    end else begin
      dec_valid_o <= req_i;
    end
  end

  // Request payload, only meaningful with dec_valid_o
  always_ff @(posedge clk_i) begin
    if (req_i) begin
      dec_target_o <= target_d;
      dec_we_o     <= we_i;
      dec_addr_o   <= addr_i;
      dec_wdata_o  <= wdata_i;
      dec_strb_o   <= strb_i;
    end
  end

endmodule : addr_decode_stage

/* l2_mem.sv */
`timescale 1ns/1ps

module l2_mem #(
  parameter int unsigned L2AddrWidth = 10
) (
  input  logic                                  clk_i,
  input  logic                                  req_i,
  input  logic                                  we_i,
  input  logic [mempool_sys_pkg::AddrWidth-1:0] addr_i,
  input  logic [mempool_sys_pkg::DataWidth-1:0] wdata_i,
  input  logic [mempool_sys_pkg::StrbWidth-1:0] strb_i,
  output logic [mempool_sys_pkg::DataWidth-1:0] rdata_o
);

  localparam int unsigned NumWords = 2 ** L2AddrWidth;

  logic [mempool_sys_pkg::DataWidth-1:0] mem_q [NumWords];
  logic [L2AddrWidth-1:0]                word_addr;

  assign word_addr = addr_i[L2AddrWidth+1:2]; // Drop the byte offset

  always_ff @(posedge clk_i) begin
    if (req_i) begin
      if (we_i) begin
        for (int unsigned b = 0; b < mempool_sys_pkg::StrbWidth; b++) begin
          if (strb_i[b]) begin
            mem_q[word_addr][8*b +: 8] <= wdata_i[8*b +: 8];
          end
        end
      end else begin
        rdata_o <= mem_q[word_addr];
      end
    end
  end

endmodule : l2_mem

/* bootrom.sv */
`timescale 1ns/1ps

module bootrom (
  input  logic                                  clk_i,
  input  logic                                  req_i,
  input  logic [mempool_sys_pkg::AddrWidth-1:0] addr_i,
  output logic [mempool_sys_pkg::DataWidth-1:0] rdata_o
);

  logic [mempool_sys_pkg::DataWidth-1:0] rom_word;

  // Contents are generated from the word index
  assign rom_word = {mempool_sys_pkg::BootromTag, addr_i[17:2]};

  always_ff @(posedge clk_i) begin
    if (req_i) begin
      rdata_o <= rom_word;
    end
  end

endmodule : bootrom

/* ctrl_regs.sv */
`timescale 1ns/1ps

module ctrl_regs #(
  parameter int unsigned                         NumCores      = 4,
  parameter int unsigned                         BankingFactor = 4,
  parameter logic [mempool_sys_pkg::AddrWidth-1:0] TCDMBaseAddr = '0
) (
  input  logic                                  clk_i,
  input  logic                                  arst_n_i,
  input  logic                                  req_i,
  input  logic                                  we_i,
  input  logic [mempool_sys_pkg::AddrWidth-1:0] addr_i,
  input  logic [mempool_sys_pkg::DataWidth-1:0] wdata_i,
  output logic [mempool_sys_pkg::DataWidth-1:0] rdata_o,
  output logic [NumCores-1:0]                   wake_up_o,
  output logic                                  eoc_valid_o
);

  localparam int unsigned TCDMSize = NumCores * BankingFactor * mempool_sys_pkg::TCDMSizePerBank;
  localparam logic [mempool_sys_pkg::DataWidth-1:0] TCDMEndAddr = TCDMBaseAddr + TCDMSize;

  logic [mempool_sys_pkg::DataWidth-1:0] eoc_q;
  logic [mempool_sys_pkg::DataWidth-1:0] read_val;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wake_up_o <= '0;
      eoc_q     <= '0;
    end else if (req_i && we_i) begin
      case (addr_i[15:0])
        mempool_sys_pkg::WakeUpReg: wake_up_o <= wdata_i[NumCores-1:0];
        mempool_sys_pkg::EocReg:    eoc_q     <= wdata_i;
        default: ;                               // Read-only or unmapped
      endcase
    end
  end

  always_comb begin
    read_val = '0;
    case (addr_i[15:0])
      mempool_sys_pkg::WakeUpReg:    read_val[NumCores-1:0] = wake_up_o;
      mempool_sys_pkg::EocReg:       read_val = eoc_q;
      mempool_sys_pkg::TcdmStartReg: read_val = TCDMBaseAddr;
      mempool_sys_pkg::TcdmEndReg:   read_val = TCDMEndAddr;
      mempool_sys_pkg::NumCoresReg:  read_val = NumCores;
      default:                       read_val = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (req_i) begin
      rdata_o <= read_val;
    end
  end

  assign eoc_valid_o = eoc_q[0];

endmodule : ctrl_regs

/* resp_merge_stage.sv */
`timescale 1ns/1ps

module resp_merge_stage (
  input  logic                                  clk_i,
  input  logic                                  arst_n_i,
  input  logic                                  dec_valid_i,
  input  logic                                  dec_we_i,
  input  mempool_sys_pkg::slave_target_e        dec_target_i,
  input  logic [mempool_sys_pkg::DataWidth-1:0] l2_rdata_i,
  input  logic [mempool_sys_pkg::DataWidth-1:0] rom_rdata_i,
  input  logic [mempool_sys_pkg::DataWidth-1:0] reg_rdata_i,
  input  logic                                  ext_rvalid_i,
  input  logic [mempool_sys_pkg::DataWidth-1:0] ext_rdata_i,
  output logic                                  rvalid_o,
  output logic [mempool_sys_pkg::DataWidth-1:0] rdata_o,
  output logic                                  busy_o
);

  logic                           d_valid_q;
  logic                           d_we_q;
  mempool_sys_pkg::slave_target_e d_target_q;
  logic                           ext_pend_q;
  logic                           ext_we_q;
  logic                           int_done;
  logic                           ext_done;

  assign int_done = d_valid_q && (d_target_q != mempool_sys_pkg::External);
  assign ext_done = ext_pend_q && ext_rvalid_i;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      d_valid_q  <= 1'b0;
      ext_pend_q <= 1'b0;
      rvalid_o   <= 1'b0;
    end else begin
      d_valid_q <= dec_valid_i;
      rvalid_o  <= int_done || ext_done;
      if (dec_valid_i && dec_target_i == mempool_sys_pkg::External) begin
        ext_pend_q <= 1'b1;
      end else if (ext_done) begin
        ext_pend_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    d_we_q     <= dec_we_i;
    d_target_q <= dec_target_i;
    if (dec_valid_i && dec_target_i == mempool_sys_pkg::External) begin
      ext_we_q <= dec_we_i;
    end
    if (ext_done) begin
      rdata_o <= ext_we_q ? '0 : ext_rdata_i;
    end else if (d_we_q) begin
      rdata_o <= '0; // Writes answer with zero
    end else begin
      case (d_target_q)
        mempool_sys_pkg::CtrlRegisters: rdata_o <= reg_rdata_i;
        mempool_sys_pkg::L2Memory:      rdata_o <= l2_rdata_i;
        mempool_sys_pkg::Bootrom:       rdata_o <= rom_rdata_i;
        default:                        rdata_o <= '0;
      endcase
    end
  end

  // High from the request edge until the pulse ends
  assign busy_o = dec_valid_i || d_valid_q || ext_pend_q || rvalid_o;

endmodule : resp_merge_stage

/* mempool_system.sv */
`timescale 1ns/1ps

module mempool_system #(
  parameter int unsigned                           NumCores      = 4,
  parameter int unsigned                           BankingFactor = 4,
  parameter logic [mempool_sys_pkg::AddrWidth-1:0] TCDMBaseAddr  = 32'h0,
  parameter int unsigned                           L2AddrWidth   = 10
) (
  input  logic                                  clk_i,
  input  logic                                  arst_n_i,
  // Host request port
  input  logic                                  req_i,
  input  logic                                  we_i,
  input  logic [mempool_sys_pkg::AddrWidth-1:0] addr_i,
  input  logic [mempool_sys_pkg::DataWidth-1:0] wdata_i,
  input  logic [mempool_sys_pkg::StrbWidth-1:0] strb_i,
  output logic                                  rvalid_o,
  output logic [mempool_sys_pkg::DataWidth-1:0] rdata_o,
  output logic                                  busy_o,
  output logic [NumCores-1:0]                   wake_up_o,
  output logic                                  eoc_valid_o,
  // External port
  output logic                                  ext_req_o,
  output logic                                  ext_we_o,
  output logic [mempool_sys_pkg::AddrWidth-1:0] ext_addr_o,
  output logic [mempool_sys_pkg::DataWidth-1:0] ext_wdata_o,
  output logic [mempool_sys_pkg::StrbWidth-1:0] ext_strb_o,
  input  logic                                  ext_rvalid_i,
  input  logic [mempool_sys_pkg::DataWidth-1:0] ext_rdata_i
);

  logic                                  dec_valid;
  mempool_sys_pkg::slave_target_e        dec_target;
  logic                                  dec_we;
  logic [mempool_sys_pkg::AddrWidth-1:0] dec_addr;
  logic [mempool_sys_pkg::DataWidth-1:0] dec_wdata;
  logic [mempool_sys_pkg::StrbWidth-1:0] dec_strb;
  logic                                  l2_req;
  logic                                  rom_req;
  logic                                  reg_req;
  logic [mempool_sys_pkg::DataWidth-1:0] l2_rdata;
  logic [mempool_sys_pkg::DataWidth-1:0] rom_rdata;
  logic [mempool_sys_pkg::DataWidth-1:0] reg_rdata;

  addr_decode_stage i_addr_decode_stage (
    .clk_i       (clk_i     ),
    .arst_n_i    (arst_n_i  ),
    .req_i       (req_i     ),
    .we_i        (we_i      ),
    .addr_i      (addr_i    ),
    .wdata_i     (wdata_i   ),
    .strb_i      (strb_i    ),
    .dec_valid_o (dec_valid ),
    .dec_target_o(dec_target),
    .dec_we_o    (dec_we    ),
    .dec_addr_o  (dec_addr  ),
    .dec_wdata_o (dec_wdata ),
    .dec_strb_o  (dec_strb  )
  );

  // One enable per target
  assign l2_req    = dec_valid && (dec_target == mempool_sys_pkg::L2Memory);
  assign rom_req   = dec_valid && (dec_target == mempool_sys_pkg::Bootrom);
  assign reg_req   = dec_valid && (dec_target == mempool_sys_pkg::CtrlRegisters);
  assign ext_req_o = dec_valid && (dec_target == mempool_sys_pkg::External);

  assign ext_we_o    = dec_we;
  assign ext_addr_o  = dec_addr;
  assign ext_wdata_o = dec_wdata;
  assign ext_strb_o  = dec_strb;

  l2_mem #(
    .L2AddrWidth(L2AddrWidth)
  ) i_l2_mem (
    .clk_i  (clk_i    ),
    .req_i  (l2_req   ),
    .we_i   (dec_we   ),
    .addr_i (dec_addr ),
    .wdata_i(dec_wdata),
    .strb_i (dec_strb ),
    .rdata_o(l2_rdata )
  );

  bootrom i_bootrom (
    .clk_i  (clk_i    ),
    .req_i  (rom_req  ),
    .addr_i (dec_addr ),
    .rdata_o(rom_rdata)
  );

  ctrl_regs #(
    .NumCores     (NumCores     ),
    .BankingFactor(BankingFactor),
    .TCDMBaseAddr (TCDMBaseAddr )
  ) i_ctrl_regs (
    .clk_i      (clk_i      ),
    .arst_n_i   (arst_n_i   ),
    .req_i      (reg_req    ),
    .we_i       (dec_we     ),
    .addr_i     (dec_addr   ),
    .wdata_i    (dec_wdata  ),
    .rdata_o    (reg_rdata  ),
    .wake_up_o  (wake_up_o  ),
    .eoc_valid_o(eoc_valid_o)
  );

  resp_merge_stage i_resp_merge_stage (
    .clk_i       (clk_i       ),
    .arst_n_i    (arst_n_i    ),
    .dec_valid_i (dec_valid   ),
    .dec_we_i    (dec_we      ),
    .dec_target_i(dec_target  ),
    .l2_rdata_i  (l2_rdata    ),
    .rom_rdata_i (rom_rdata   ),
    .reg_rdata_i (reg_rdata   ),
    .ext_rvalid_i(ext_rvalid_i),
    .ext_rdata_i (ext_rdata_i ),
    .rvalid_o    (rvalid_o    ),
    .rdata_o     (rdata_o     ),
    .busy_o      (busy_o      )
  );

endmodule : mempool_system

/* tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int unsigned PeriodNs = 100
) (
  output logic clk_o
);

  initial begin
    clk_o = 1'b0;
  end

  always #(PeriodNs / 2) clk_o = ~clk_o;

endmodule : tb_clock_gen

/* mempool_system_asserts.sv */
`timescale 1ns/1ps

module mempool_system_asserts (
  input logic                                  clk_i,
  input logic                                  arst_n_i,
  input logic                                  req_i,
  input logic                                  we_i,
  input logic [mempool_sys_pkg::AddrWidth-1:0] addr_i,
  input logic [mempool_sys_pkg::DataWidth-1:0] wdata_i,
  input logic                                  rvalid_i,
  input logic                                  busy_i,
  input logic                                  eoc_valid_i,
  input logic                                  ext_req_i,
  input logic                                  ext_rvalid_i,
  input logic                                  dec_valid_i,
  input mempool_sys_pkg::slave_target_e        dec_target_i
);

  int unsigned fail_count = 0;

  logic       ext_out_q; // External request awaiting its answer
  logic       eoc_wr_q;
  logic       eoc_bit_q;
  logic       eoc_exp_q;
  logic [2:0] due_q;     // Responses still owed to the host
  logic       eoc_write;

  // Host write to EocReg, the register takes it one edge after the request edge
  assign eoc_write = req_i && we_i &&
                     (addr_i == mempool_sys_pkg::CtrlRegistersBaseAddr
                                + 32'(mempool_sys_pkg::EocReg));

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ext_out_q <= 1'b0;
      eoc_wr_q  <= 1'b0;
      eoc_bit_q <= 1'b0;
      eoc_exp_q <= 1'b0;
      due_q     <= '0;
    end else begin
      if (ext_req_i) begin
        ext_out_q <= 1'b1;
      end else if (ext_rvalid_i) begin
        ext_out_q <= 1'b0;
      end
      eoc_wr_q  <= eoc_write;
      eoc_bit_q <= wdata_i[0];
      if (eoc_wr_q) begin
        eoc_exp_q <= eoc_bit_q;
      end
      due_q <= due_q + 3'(req_i) - 3'(rvalid_i);
    end
  end

  // Decode stage is one cycle behind the host edge
  internal_latency: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    dec_valid_i && (dec_target_i != mempool_sys_pkg::External) |-> ##2 rvalid_i)
    else begin
      $error("Internal request got no response two cycles after it");
      fail_count++;
    end

  no_req_while_ext: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (ext_req_i || ext_out_q) |-> !req_i)
    else begin
      $error("Host request issued while an External request was outstanding");
      fail_count++;
    end

  ext_req_single: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    ext_req_i |=> !ext_req_i)
    else begin
      $error("External request strobe lasted more than one cycle");
      fail_count++;
    end

  eoc_follows_write: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    eoc_valid_i == eoc_exp_q)
    else begin
      $error("eoc_valid_o differs from bit 0 of the last EocReg write");
      fail_count++;
    end

  busy_while_due: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (due_q != '0) |-> busy_i)
    else begin
      $error("busy_o low while a response was still due");
      fail_count++;
    end

endmodule : mempool_system_asserts

bind mempool_system mempool_system_asserts mempool_system_asserts_inst (
  .clk_i       (clk_i       ),
  .arst_n_i    (arst_n_i    ),
  .req_i       (req_i       ),
  .we_i        (we_i        ),
  .addr_i      (addr_i      ),
  .wdata_i     (wdata_i     ),
  .rvalid_i    (rvalid_o    ),
  .busy_i      (busy_o      ),
  .eoc_valid_i (eoc_valid_o ),
  .ext_req_i   (ext_req_o   ),
  .ext_rvalid_i(ext_rvalid_i),
  .dec_valid_i (dec_valid   ),
  .dec_target_i(dec_target  )
);

/* tb_mempool_system.sv */
`timescale 1ns/1ps

module tb_mempool_system;

  localparam int unsigned NumCores      = 4;
  localparam int unsigned BankingFactor = 4;
  localparam logic [31:0] TCDMBaseAddr  = 32'h0;
  localparam int unsigned L2AddrWidth   = 10;

  localparam int unsigned ClkPeriodNs  = 100;
  localparam int unsigned ResetCycles  = 5;
  localparam int unsigned RespTimeout  = 12;
  localparam int unsigned NumL2Writes  = 12;
  localparam int unsigned NumRomReads  = 16;
  localparam int unsigned NumExtReqs   = 10;
  localparam int unsigned ReqCycles    = 8;  // One internal request with margin
  localparam int unsigned ExtReqCycles = 12;
  localparam int unsigned TestCycles   = ResetCycles + 2 + NumL2Writes * 3 * ReqCycles
                                         + NumRomReads + ReqCycles + 12 * ReqCycles
                                         + (NumExtReqs + 3) * ExtReqCycles + 5 * ExtReqCycles;

  localparam logic [31:0] WakeUpAddr   = mempool_sys_pkg::CtrlRegistersBaseAddr
                                         + 32'(mempool_sys_pkg::WakeUpReg);
  localparam logic [31:0] EocAddr      = mempool_sys_pkg::CtrlRegistersBaseAddr
                                         + 32'(mempool_sys_pkg::EocReg);
  localparam logic [31:0] TcdmStartAdr = mempool_sys_pkg::CtrlRegistersBaseAddr
                                         + 32'(mempool_sys_pkg::TcdmStartReg);
  localparam logic [31:0] TcdmEndAdr   = mempool_sys_pkg::CtrlRegistersBaseAddr
                                         + 32'(mempool_sys_pkg::TcdmEndReg);
  localparam logic [31:0] NumCoresAdr  = mempool_sys_pkg::CtrlRegistersBaseAddr
                                         + 32'(mempool_sys_pkg::NumCoresReg);

  logic                clk_i;
  logic                arst_n_i;
  logic                req_i;
  logic                we_i;
  logic [31:0]         addr_i;
  logic [31:0]         wdata_i;
  logic [3:0]          strb_i;
  logic                rvalid_o;
  logic [31:0]         rdata_o;
  logic                busy_o;
  logic [NumCores-1:0] wake_up_o;
  logic                eoc_valid_o;
  logic                ext_req_o;
  logic                ext_we_o;
  logic [31:0]         ext_addr_o;
  logic [31:0]         ext_wdata_o;
  logic [3:0]          ext_strb_o;
  logic                ext_rvalid_i;
  logic [31:0]         ext_rdata_i;

  logic [31:0] exp_q [$];           // Expected response data, oldest first
  logic [31:0] l2_model [int unsigned];
  string       cur_test;
  int unsigned errors = 0;
  int unsigned tests_pass = 0;
  int unsigned tests_fail = 0;
  int unsigned test_start_fails;
  int unsigned ext_seen_cnt = 0;
  logic [31:0] host_addr;
  logic [31:0] host_wdata;
  logic        host_we;
  logic [3:0]  host_strb;

  tb_clock_gen #(.PeriodNs(ClkPeriodNs)) i_clock_gen (.clk_o(clk_i));

  mempool_system #(
    .NumCores     (NumCores     ),
    .BankingFactor(BankingFactor),
    .TCDMBaseAddr (TCDMBaseAddr ),
    .L2AddrWidth  (L2AddrWidth  )
  ) mempool_system_inst (
    .clk_i       (clk_i       ),
    .arst_n_i    (arst_n_i    ),
    .req_i       (req_i       ),
    .we_i        (we_i        ),
    .addr_i      (addr_i      ),
    .wdata_i     (wdata_i     ),
    .strb_i      (strb_i      ),
    .rvalid_o    (rvalid_o    ),
    .rdata_o     (rdata_o     ),
    .busy_o      (busy_o      ),
    .wake_up_o   (wake_up_o   ),
    .eoc_valid_o (eoc_valid_o ),
    .ext_req_o   (ext_req_o   ),
    .ext_we_o    (ext_we_o    ),
    .ext_addr_o  (ext_addr_o  ),
    .ext_wdata_o (ext_wdata_o ),
    .ext_strb_o  (ext_strb_o  ),
    .ext_rvalid_i(ext_rvalid_i),
    .ext_rdata_i (ext_rdata_i )
  );

  function automatic int unsigned total_fails();
    return errors + mempool_system_inst.mempool_system_asserts_inst.fail_count;
  endfunction

  function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                              input logic [31:0] new_word,
                                              input logic [3:0]  strb);
    logic [31:0] res;
    res = old_word;
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) res[8*b +: 8] = new_word[8*b +: 8];
    end
    return res;
  endfunction

  task automatic check_value(input string what, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp) else begin
      $display("FAILED %s %s: expected %h, actual %h", cur_test, what, exp, act);
      errors++;
    end
  endtask

  task automatic start_test(input string name);
    cur_test         = name;
    test_start_fails = total_fails();
  endtask

  task automatic end_test();
    if (total_fails() == test_start_fails) begin
      tests_pass++;
      $display("Test %s passed", cur_test);
    end else begin
      tests_fail++;
      $display("Test %s failed with %0d errors", cur_test, total_fails() - test_start_fails);
    end
  endtask

  task automatic issue_req(input logic we, input logic [31:0] addr, input logic [31:0] wdata,
                           input logic [3:0] strb, input logic [31:0] exp);
    @(negedge clk_i);
    req_i      = 1'b1;
    we_i       = we;
    addr_i     = addr;
    wdata_i    = wdata;
    strb_i     = strb;
    host_we    = we;
    host_addr  = addr;
    host_wdata = wdata;
    host_strb  = strb;
    exp_q.push_back(exp);
  endtask

  task automatic release_bus();
    @(negedge clk_i);
    req_i = 1'b0;
    we_i  = 1'b0;
  endtask

  task automatic wait_responses();
    int unsigned cycles;
    cycles = 0;
    while (exp_q.size() != 0 && cycles < RespTimeout) begin
      @(posedge clk_i);
      cycles++;
    end
    if (exp_q.size() != 0) begin
      $display("Timeout: %0d responses never arrived in test %s", exp_q.size(), cur_test);
      errors++;
      exp_q.delete();
    end
    @(negedge clk_i);
  endtask

  task automatic single_req(input logic we, input logic [31:0] addr, input logic [31:0] wdata,
                            input logic [3:0] strb, input logic [31:0] exp);
    issue_req(we, addr, wdata, strb, exp);
    release_bus();
    wait_responses();
  endtask

  // Response monitor, outputs are stable at the falling edge
  always @(negedge clk_i) begin
    if (arst_n_i && rvalid_o) begin
      if (exp_q.size() == 0) begin
        $display("Response pulse with no request pending in test %s", cur_test);
        errors++;
      end else begin
        check_value("rdata_o", exp_q.pop_front(), rdata_o);
      end
    end
  end

  // External target model
  initial begin : ext_model
    int unsigned delay;
    logic [31:0] addr;
    ext_rvalid_i = 1'b0;
    ext_rdata_i  = '0;
    forever begin
      @(negedge clk_i);
      if (arst_n_i && ext_req_o) begin
        addr = ext_addr_o;
        ext_seen_cnt++;
        check_value("ext_addr_o", host_addr, ext_addr_o);
        check_value("ext_we_o", 32'(host_we), 32'(ext_we_o));
        check_value("ext_strb_o", 32'(host_strb), 32'(ext_strb_o));
        if (host_we) check_value("ext_wdata_o", host_wdata, ext_wdata_o);
        delay = 1 + ($urandom % 4);
        repeat (delay) @(negedge clk_i);
        ext_rvalid_i = 1'b1;
        ext_rdata_i  = addr ^ 32'h5A5A_5A5A;
        @(negedge clk_i);
        ext_rvalid_i = 1'b0;
      end
    end
  end

  initial begin : watchdog
    #(TestCycles * ClkPeriodNs * 2);
    $display("Watchdog expired before the tests completed");
    $display("Checks failed");
    $finish;
  end

  initial begin : stimulus
    logic [31:0]         addr;
    logic [31:0]         data;
    logic [3:0]          strb;
    logic                we;
    logic [NumCores-1:0] wake;
    int unsigned         idx;
    int unsigned         ext_before;

    void'($urandom(32'h1566539b));
    arst_n_i = 1'b0;
    req_i    = 1'b0;
    we_i     = 1'b0;
    addr_i   = '0;
    wdata_i  = '0;
    strb_i   = '0;

    start_test("reset");
    repeat (ResetCycles) @(negedge clk_i);
    arst_n_i = 1'b1;
    @(negedge clk_i);
    check_value("rvalid_o", 32'h0, 32'(rvalid_o));
    check_value("busy_o", 32'h0, 32'(busy_o));
    check_value("eoc_valid_o", 32'h0, 32'(eoc_valid_o));
    check_value("wake_up_o", 32'h0, 32'(wake_up_o));
    end_test();

    start_test("l2_rw");
    for (int i = 0; i < NumL2Writes; i++) begin
      addr = mempool_sys_pkg::L2MemoryBaseAddr | ($urandom & 32'h001F_FFFC);
      idx  = addr[L2AddrWidth+1:2];
      if (!l2_model.exists(idx)) begin
        data = $urandom;
        single_req(1'b1, addr, data, 4'hF, 32'h0);
        l2_model[idx] = data;
      end
      data = $urandom;
      strb = 4'($urandom);
      single_req(1'b1, addr, data, strb, 32'h0);
      l2_model[idx] = merge_bytes(l2_model[idx], data, strb);
      single_req(1'b0, addr, $urandom, 4'h0, l2_model[idx]);
    end
    end_test();

    start_test("bootrom");
    for (int i = 0; i < NumRomReads; i++) begin
      addr = mempool_sys_pkg::BootromBaseAddr | ($urandom & 32'h0000_FFFC);
      issue_req(1'b0, addr, '0, '0, {mempool_sys_pkg::BootromTag, addr[17:2]});
    end
    release_bus();
    wait_responses();
    end_test();

    start_test("ctrl_regs");
    wake = NumCores'($urandom);
    single_req(1'b1, WakeUpAddr, 32'(wake), 4'hF, 32'h0);
    check_value("wake_up_o", 32'(wake), 32'(wake_up_o));
    single_req(1'b0, WakeUpAddr, '0, '0, 32'(wake));
    single_req(1'b1, EocAddr, 32'h1, 4'hF, 32'h0);
    check_value("eoc_valid_o", 32'h1, 32'(eoc_valid_o));
    single_req(1'b0, EocAddr, '0, '0, 32'h1);
    single_req(1'b0, TcdmStartAdr, '0, '0, TCDMBaseAddr);
    single_req(1'b0, TcdmEndAdr, '0, '0,
               TCDMBaseAddr + NumCores * BankingFactor * mempool_sys_pkg::TCDMSizePerBank);
    single_req(1'b0, NumCoresAdr, '0, '0, NumCores);
    single_req(1'b1, mempool_sys_pkg::CtrlRegistersBaseAddr + 32'h14, $urandom, 4'hF, 32'h0);
    single_req(1'b0, mempool_sys_pkg::CtrlRegistersBaseAddr + 32'h14, '0, '0, 32'h0);
    single_req(1'b0, mempool_sys_pkg::CtrlRegistersBaseAddr + 32'h100, '0, '0, 32'h0);
    end_test();

    start_test("external");
    ext_before = ext_seen_cnt;
    for (int i = 0; i < NumExtReqs + 3; i++) begin
      case (i)
        0:       addr = 32'h4001_0000; // Just past the register window
        1:       addr = 32'h8020_0000;
        2:       addr = 32'hFFFF_FFFC;
        default: addr = $urandom & 32'h3FFF_FFFC;
      endcase
      we   = 1'($urandom);
      data = $urandom;
      strb = 4'($urandom);
      single_req(we, addr, data, strb, we ? 32'h0 : (addr ^ 32'h5A5A_5A5A));
    end
    check_value("External request count", NumExtReqs + 3, ext_seen_cnt - ext_before);
    end_test();

    start_test("write_resp");
    single_req(1'b1, mempool_sys_pkg::L2MemoryBaseAddr + 32'h40, $urandom, 4'hF, 32'h0);
    single_req(1'b1, mempool_sys_pkg::BootromBaseAddr + 32'h8, $urandom, 4'hF, 32'h0);
    single_req(1'b1, mempool_sys_pkg::CtrlRegistersBaseAddr + 32'h20, $urandom, 4'hF, 32'h0);
    single_req(1'b1, 32'h1000_0000, $urandom, 4'hF, 32'h0);
    single_req(1'b1, EocAddr, 32'h0, 4'hF, 32'h0);
    check_value("eoc_valid_o", 32'h0, 32'(eoc_valid_o));
    end_test();

    $display("Summary: %0d tests passed, %0d tests failed, %0d failed checks",
             tests_pass, tests_fail, total_fails());
    if (total_fails() == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule : tb_mempool_system

/* compile.f */
mempool_sys_pkg.sv
addr_decode_stage.sv
l2_mem.sv
bootrom.sv
ctrl_regs.sv
resp_merge_stage.sv
mempool_system.sv
tb_clock_gen.sv
mempool_system_asserts.sv
tb_mempool_system.sv

/* Bender.yml */
package:
  name: mempool_system

sources:
  - mempool_sys_pkg.sv
  - addr_decode_stage.sv
  - l2_mem.sv
  - bootrom.sv
  - ctrl_regs.sv
  - resp_merge_stage.sv
  - mempool_system.sv
  - target: test
    files:
      - tb_clock_gen.sv
      - mempool_system_asserts.sv
      - tb_mempool_system.sv
